/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = renameUnitTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

/* compile.f */
+incdir+src
src/renamePkg.sv
src/tagBuffer.sv
src/registerAliasTable.sv
src/renameLane.sv
src/renameUnit.sv
testbench/renameUnit_sva.sv
testbench/renameUnitTb.sv

/* src/registerAliasTable.sv */
`include "renameSettings.svh"

module registerAliasTable import renamePkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              mispredict,
    input  DecodedUop         inGroup [`RENAME_WIDTH],
    input  logic [`TAG_W-1:0] newTags [`RENAME_WIDTH],
    input  logic              allocate [`RENAME_WIDTH],
    input  CommitSlot         commitSlots [`RENAME_WIDTH],
    output LookupResult       lookups [`RENAME_WIDTH],
    output logic [`TAG_W-1:0] commitPrevTags [`RENAME_WIDTH]
);

    logic [`TAG_W-1:0] specMap [`NUM_ARCH_REGS];
    logic [`TAG_W-1:0] commMap [`NUM_ARCH_REGS];
    logic [`TAG_W-1:0] specNext [`NUM_ARCH_REGS];
    logic [`TAG_W-1:0] commNext [`NUM_ARCH_REGS];

    // ------------------------------------------------------------
    // source and prevTag lookup
    // ------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            lookups[i].srcATag = specMap[inGroup[i].srcAArch];
            lookups[i].srcBTag = specMap[inGroup[i].srcBArch];
            lookups[i].prevTag = specMap[inGroup[i].dstArch];

            // older lanes in ascending order, youngest match wins
            for (int j = 0; j < i; j++) begin
                if (inGroup[j].valid && writesDst(inGroup[j].op)) begin
                    if (inGroup[j].dstArch == inGroup[i].srcAArch) begin
                        lookups[i].srcATag = newTags[j];
                    end
                    if (inGroup[j].dstArch == inGroup[i].srcBArch) begin
                        lookups[i].srcBTag = newTags[j];
                    end
                    if (inGroup[j].dstArch == inGroup[i].dstArch) begin
                        lookups[i].prevTag = newTags[j];
                    end
                end
            end
        end
    end

    // committed prevTag, forwarded from older commit slots
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            commitPrevTags[i] = commMap[commitSlots[i].dstArch];
            for (int j = 0; j < i; j++) begin
                if (commitSlots[j].valid && commitSlots[j].newest &&
                    commitSlots[j].dstArch == commitSlots[i].dstArch) begin
                    commitPrevTags[i] = commitSlots[j].dstTag;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // map updates
    // ------------------------------------------------------------

    always_comb begin
        commNext = commMap;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (commitSlots[i].valid && commitSlots[i].newest) begin
                commNext[commitSlots[i].dstArch] = commitSlots[i].dstTag;
            end
        end
    end

    always_comb begin
        if (mispredict) begin
            specNext = commNext;  // includes this cycle's commits
        end else begin
            specNext = specMap;
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (allocate[i]) begin  // youngest lane written last
                    specNext[inGroup[i].dstArch] = newTags[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                specMap[r] <= `TAG_W'(r);
                commMap[r] <= `TAG_W'(r);
            end
        end else begin
            specMap <= specNext;
            commMap <= commNext;
        end
    end

endmodule

/* src/renameLane.sv */
`include "renameSettings.svh"

module renameLane import renamePkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  DecodedUop         uop,
    input  LookupResult       lookup,
    input  logic [`TAG_W-1:0] newTag,
    input  logic              stall,
    input  logic              mispredict,
    output logic              needTag,
    output logic              allocate,
    output RenamedUop         renamed
);

    RenamedUop renamedNext;

    assign needTag  = uop.valid && writesDst(uop.op);
    assign allocate = needTag && !stall;

    // ------------------------------------------------------------
    // assemble renamed micro-op
    // ------------------------------------------------------------

    always_comb begin
        renamedNext.valid   = uop.valid && !stall && !mispredict;
        renamedNext.op      = uop.op;
        renamedNext.srcATag = lookup.srcATag;
        renamedNext.srcBTag = lookup.srcBTag;
        if (needTag) begin
            renamedNext.dstTag  = newTag;
            renamedNext.prevTag = lookup.prevTag;
        end else begin
            renamedNext.dstTag  = '0;  // stores and branches
            renamedNext.prevTag = '0;
        end
    end

    always_ff @(posedge clk) begin
        renamed <= renamedNext;
        if (rst) begin
            renamed.valid <= 1'b0;
        end
    end

endmodule

/* src/renamePkg.sv */
`include "renameSettings.svh"

package renamePkg;

    typedef enum logic [1:0] {
        opAlu,
        opLoad,
        opStore,
        opBranch
    } UopOp;

    // ------------------------------------------------------------
    // micro-op formats
    // ------------------------------------------------------------

    typedef struct packed {
        logic               valid;
        UopOp               op;
        logic [`ARCH_W-1:0] dstArch;
        logic [`ARCH_W-1:0] srcAArch;
        logic [`ARCH_W-1:0] srcBArch;
    } DecodedUop;

    typedef struct packed {
        logic              valid;
        UopOp              op;
        logic [`TAG_W-1:0] dstTag;
        logic [`TAG_W-1:0] prevTag;  // old mapping of dstArch
        logic [`TAG_W-1:0] srcATag;
        logic [`TAG_W-1:0] srcBTag;
    } RenamedUop;

    typedef struct packed {
        logic               valid;
        logic               newest;  // last writer of dstArch in flight
        logic [`ARCH_W-1:0] dstArch;
        logic [`TAG_W-1:0]  dstTag;
    } CommitSlot;

    typedef struct packed {
        logic [`TAG_W-1:0] srcATag;
        logic [`TAG_W-1:0] srcBTag;
        logic [`TAG_W-1:0] prevTag;
    } LookupResult;

    // alu and load results go to a register
    function automatic logic writesDst(UopOp op);
        return (op == opAlu) || (op == opLoad);
    endfunction

endpackage

/* src/renameSettings.svh */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// ------------------------------------------------------------
// rename stage sizing
// ------------------------------------------------------------

`define RENAME_WIDTH   3   // micro-ops per group
`define NUM_TAGS       64  // physical tags
`define TAG_W          6

// architectural register file
`define NUM_ARCH_REGS  32
`define ARCH_W         5

`endif

/* src/renameUnit.sv */
`include "renameSettings.svh"

module renameUnit import renamePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  DecodedUop inGroup [`RENAME_WIDTH],
    input  logic      mispredict,
    input  CommitSlot commitSlots [`RENAME_WIDTH],
    output logic      inStall,
    output RenamedUop outGroup [`RENAME_WIDTH]
);

    LookupResult       lookups [`RENAME_WIDTH];
    logic [`TAG_W-1:0] offerTags [`RENAME_WIDTH];
    logic [`TAG_W-1:0] commitPrevTags [`RENAME_WIDTH];
    logic              needTag [`RENAME_WIDTH];
    logic              allocate [`RENAME_WIDTH];
    logic              stall;

    assign inStall = stall;

    registerAliasTable u_rat (
        .clk            (clk),
        .rst            (rst),
        .mispredict     (mispredict),
        .inGroup        (inGroup),
        .newTags        (offerTags),
        .allocate       (allocate),
        .commitSlots    (commitSlots),
        .lookups        (lookups),
        .commitPrevTags (commitPrevTags)
    );

    // ------------------------------------------------------------
    // lanes
    // ------------------------------------------------------------

    for (genvar i = 0; i < `RENAME_WIDTH; i++) begin : g_lane
        renameLane u_lane (
            .clk        (clk),
            .rst        (rst),
            .uop        (inGroup[i]),
            .lookup     (lookups[i]),
            .newTag     (offerTags[i]),
            .stall      (stall),
            .mispredict (mispredict),
            .needTag    (needTag[i]),
            .allocate   (allocate[i]),
            .renamed    (outGroup[i])
        );
    end

    tagBuffer u_tagBuffer (
        .clk            (clk),
        .rst            (rst),
        .mispredict     (mispredict),
        .needTag        (needTag),
        .allocate       (allocate),
        .commitSlots    (commitSlots),
        .commitPrevTags (commitPrevTags),
        .offerTags      (offerTags),
        .stall          (stall)
    );

endmodule

/* src/tagBuffer.sv */
`include "renameSettings.svh"

module tagBuffer import renamePkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              mispredict,
    input  logic              needTag [`RENAME_WIDTH],
    input  logic              allocate [`RENAME_WIDTH],
    input  CommitSlot         commitSlots [`RENAME_WIDTH],
    input  logic [`TAG_W-1:0] commitPrevTags [`RENAME_WIDTH],
    output logic [`TAG_W-1:0] offerTags [`RENAME_WIDTH],
    output logic              stall
);

    logic [`NUM_TAGS-1:0] used;
    logic [`NUM_TAGS-1:0] committed;
    logic [`NUM_TAGS-1:0] usedNext;
    logic [`NUM_TAGS-1:0] committedNext;
    logic [`NUM_TAGS-1:0] taken;
    logic                 offerValid [`RENAME_WIDTH];

    // ------------------------------------------------------------
    // tag selection, highest free tag to lane 0
    // ------------------------------------------------------------

    always_comb begin
        taken = used;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            offerTags[i]  = '0;
            offerValid[i] = 1'b0;
            for (int t = 0; t < `NUM_TAGS; t++) begin
                if (!taken[t]) begin  // last hit is the highest
                    offerTags[i]  = `TAG_W'(t);
                    offerValid[i] = 1'b1;
                end
            end
            if (offerValid[i]) begin
                taken[offerTags[i]] = 1'b1;  // keep later lanes off it
            end
        end
    end

    // whole group waits if any needy lane has no offer
    always_comb begin
        stall = 1'b0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (needTag[i] && !offerValid[i]) begin
                stall = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // state update
    // ------------------------------------------------------------

    always_comb begin
        usedNext      = used;
        committedNext = committed;

        if (mispredict) begin
            usedNext = used & committed;  // drop all speculative tags
        end else begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (allocate[i]) begin
                    usedNext[offerTags[i]] = 1'b1;
                end
            end
        end

        // commits go last so they win over allocation and flush
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (commitSlots[i].valid) begin
                if (commitSlots[i].newest) begin
                    usedNext[commitPrevTags[i]]      = 1'b0;
                    committedNext[commitPrevTags[i]] = 1'b0;
                    usedNext[commitSlots[i].dstTag]      = 1'b1;
                    committedNext[commitSlots[i].dstTag] = 1'b1;
                end else begin
                    usedNext[commitSlots[i].dstTag]      = 1'b0;  // overwritten in flight
                    committedNext[commitSlots[i].dstTag] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < `NUM_TAGS; t++) begin
                used[t]      <= (t < `NUM_ARCH_REGS);  // identity map owns low tags
                committed[t] <= (t < `NUM_ARCH_REGS);
            end
        end else begin
            used      <= usedNext;
            committed <= committedNext;
        end
    end

endmodule

/* testbench/renameUnitTb.sv */
`include "renameSettings.svh"

module renameUnitTb import renamePkg::*; ();

    typedef DecodedUop [`RENAME_WIDTH-1:0] InVec;
    typedef CommitSlot [`RENAME_WIDTH-1:0] CommitVec;
    typedef RenamedUop [`RENAME_WIDTH-1:0] OutVec;

    localparam int numRows = 17;

    logic      clk;
    logic      rst;
    logic      mispredict;
    logic      inStall;
    DecodedUop inGroup [`RENAME_WIDTH];
    CommitSlot commitSlots [`RENAME_WIDTH];
    RenamedUop outGroup [`RENAME_WIDTH];

    string    rowName [numRows];
    InVec     rowIn [numRows];
    CommitVec rowCommit [numRows];
    logic     rowMispredict [numRows];
    logic     rowStall [numRows];
    OutVec    rowExp [numRows];
    int       rowCount = 0;
    int       okCount = 0;
    int       badCount = 0;
    logic     stallSeen;

    renameUnit u_dut (
        .clk         (clk),
        .rst         (rst),
        .inGroup     (inGroup),
        .mispredict  (mispredict),
        .commitSlots (commitSlots),
        .inStall     (inStall),
        .outGroup    (outGroup)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------

    function automatic DecodedUop decoded(UopOp op, int dst, int srcA, int srcB);
        DecodedUop u;
        u.valid    = 1'b1;
        u.op       = op;
        u.dstArch  = `ARCH_W'(dst);
        u.srcAArch = `ARCH_W'(srcA);
        u.srcBArch = `ARCH_W'(srcB);
        return u;
    endfunction

    function automatic RenamedUop renamed(UopOp op, int dst, int prev, int srcA, int srcB);
        RenamedUop u;
        u.valid   = 1'b1;
        u.op      = op;
        u.dstTag  = `TAG_W'(dst);
        u.prevTag = `TAG_W'(prev);
        u.srcATag = `TAG_W'(srcA);
        u.srcBTag = `TAG_W'(srcB);
        return u;
    endfunction

    function automatic CommitSlot retired(logic newest, int arch, int tag);
        CommitSlot c;
        c.valid   = 1'b1;
        c.newest  = newest;
        c.dstArch = `ARCH_W'(arch);
        c.dstTag  = `TAG_W'(tag);
        return c;
    endfunction

    task automatic addRow(input string name, input logic mp, input logic st,
                          input CommitSlot c0, input CommitSlot c1, input CommitSlot c2,
                          input DecodedUop i0, input DecodedUop i1, input DecodedUop i2,
                          input RenamedUop e0, input RenamedUop e1, input RenamedUop e2);
        if (rowCount < numRows) begin
            rowName[rowCount]       = name;
            rowMispredict[rowCount] = mp;
            rowStall[rowCount]      = st;
            rowCommit[rowCount]     = {c2, c1, c0};
            rowIn[rowCount]         = {i2, i1, i0};
            rowExp[rowCount]        = {e2, e1, e0};
        end
        rowCount++;
    endtask

    task automatic buildTable();
        int p0;
        int p1;
        int p2;
        // identity map after reset, free tags 32..63 handed out from the top
        addRow("reset_lookup", 1'b0, 1'b0, '0, '0, '0,
            decoded(opAlu, 1, 2, 3), decoded(opAlu, 4, 5, 6), decoded(opAlu, 7, 8, 9),
            renamed(opAlu, 63, 1, 2, 3), renamed(opAlu, 62, 4, 5, 6),
            renamed(opAlu, 61, 7, 8, 9));
        addRow("forward", 1'b0, 1'b0, '0, '0, '0,
            decoded(opAlu, 10, 1, 2), decoded(opAlu, 11, 10, 4), decoded(opAlu, 10, 11, 7),
            renamed(opAlu, 60, 10, 63, 2), renamed(opAlu, 59, 11, 60, 62),
            renamed(opAlu, 58, 60, 59, 61));
        // store keeps its offer unused, r13 not forwarded from it
        addRow("store_skip", 1'b0, 1'b0, '0, '0, '0,
            decoded(opAlu, 12, 10, 0), decoded(opStore, 13, 12, 11), decoded(opAlu, 13, 12, 13),
            renamed(opAlu, 57, 12, 58, 0), renamed(opStore, 0, 0, 57, 59),
            renamed(opAlu, 55, 13, 57, 13));
        addRow("commit", 1'b0, 1'b0, retired(1'b1, 7, 61), retired(1'b1, 4, 62),
            retired(1'b0, 10, 60), '0, '0, '0, '0, '0, '0);
        addRow("reuse_freed", 1'b0, 1'b0, '0, '0, '0,
            decoded(opAlu, 14, 1, 4), decoded(opAlu, 15, 14, 15), decoded(opLoad, 16, 15, 16),
            renamed(opAlu, 60, 14, 63, 62), renamed(opAlu, 56, 15, 60, 15),
            renamed(opLoad, 54, 16, 56, 16));
        for (int k = 0; k < 7; k++) begin
            p0 = (k == 0) ? 20 : 56 - 3 * k;  // previous fill's tags
            p1 = (k == 0) ? 21 : 55 - 3 * k;
            p2 = (k == 0) ? 22 : 54 - 3 * k;
            addRow($sformatf("fill_%0d", k), 1'b0, 1'b0, '0, '0, '0,
                decoded(opAlu, 20, 20, 0), decoded(opAlu, 21, 21, 0), decoded(opAlu, 22, 22, 0),
                renamed(opAlu, 53 - 3 * k, p0, p0, 0), renamed(opAlu, 52 - 3 * k, p1, p1, 0),
                renamed(opAlu, 51 - 3 * k, p2, p2, 0));
        end
        addRow("last_tags", 1'b0, 1'b0, '0, '0, '0,
            decoded(opAlu, 20, 20, 0), decoded(opAlu, 21, 21, 0), decoded(opAlu, 22, 22, 0),
            renamed(opAlu, 32, 35, 35, 0), renamed(opAlu, 7, 34, 34, 0),
            renamed(opAlu, 4, 33, 33, 0));
        addRow("stall_alu", 1'b0, 1'b1, '0, '0, '0,
            decoded(opAlu, 5, 0, 0), '0, '0, '0, '0, '0);
        addRow("stall_store_ok", 1'b0, 1'b0, '0, '0, '0,
            decoded(opStore, 0, 20, 1), decoded(opBranch, 0, 21, 22), '0,
            renamed(opStore, 0, 0, 32, 63), renamed(opBranch, 0, 0, 7, 4), '0);
        addRow("mispredict", 1'b1, 1'b0, retired(1'b1, 14, 60), '0, '0,
            decoded(opStore, 0, 1, 2), '0, '0, '0, '0, '0);
        addRow("after_flush", 1'b0, 1'b0, '0, '0, '0,
            decoded(opAlu, 20, 14, 1), decoded(opAlu, 21, 20, 7), decoded(opAlu, 10, 16, 4),
            renamed(opAlu, 63, 20, 60, 1), renamed(opAlu, 59, 21, 63, 61),
            renamed(opAlu, 58, 10, 16, 62));
    endtask

    // ------------------------------------------------------------
    // drive and compare
    // ------------------------------------------------------------

    task automatic applyRow(input int r);
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            inGroup[l]     = rowIn[r][l];
            commitSlots[l] = rowCommit[r][l];
        end
        mispredict = rowMispredict[r];
    endtask

    function automatic string uopText(RenamedUop u);
        if (!u.valid) begin
            return "invalid";
        end
        return $sformatf("op %0d dst %0d prev %0d srcA %0d srcB %0d",
                         u.op, u.dstTag, u.prevTag, u.srcATag, u.srcBTag);
    endfunction

    task automatic checkRow(input int r);
        int        errs;
        RenamedUop want;
        errs = 0;
        if (stallSeen !== rowStall[r]) begin
            $display("** Error %s stall: expected %0b, actual %0b",
                     rowName[r], rowStall[r], stallSeen);
            errs++;
        end
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            want = rowExp[r][l];
            // invalid lanes carry don't-care fields
            if ((want.valid && outGroup[l] !== want) ||
                (!want.valid && outGroup[l].valid !== 1'b0)) begin
                $display("** Error %s lane %0d: expected %s, actual %s",
                         rowName[r], l, uopText(want), uopText(outGroup[l]));
                errs++;
            end
        end
        if (errs == 0) begin
            okCount++;
        end else begin
            badCount++;
        end
        $display("%s: %s", rowName[r], (errs == 0) ? "ok" : "mismatch");
    endtask

    // ------------------------------------------------------------
    // run
    // ------------------------------------------------------------

    initial begin
        rst        = 1'b1;
        mispredict = 1'b0;
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            inGroup[l]     = '0;
            commitSlots[l] = '0;
        end
        buildTable();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < numRows; r++) begin
            applyRow(r);
            @(negedge clk);
            stallSeen = inStall;  // settled mid-cycle
            @(posedge clk);
            #1;
            checkRow(r);
        end
        if (rowCount != numRows) begin
            $display("stimulus table holds %0d rows but %0d were run", rowCount, numRows);
            badCount++;
        end
        $display("rows %0d, ok %0d, mismatched %0d", numRows, okCount, badCount);
        if (badCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #((numRows + 20) * 10 * 4);
        $display("timeout: the stimulus rows did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* testbench/renameUnit_sva.sv */
`include "renameSettings.svh"

module renameUnit_sva import renamePkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 mispredict,
    input logic                 stall,
    input logic                 allocate [`RENAME_WIDTH],
    input logic [`TAG_W-1:0]    offerTags [`RENAME_WIDTH],
    input logic [`NUM_TAGS-1:0] used,
    input RenamedUop            outGroup [`RENAME_WIDTH]
);

    // a stalled group takes nothing, so no free tag turns used
    assert property (@(posedge clk) disable iff (rst) stall |=> (used & ~$past(used)) == '0)
        else $error("a free tag was marked used while stall was high");

    for (genvar i = 0; i < `RENAME_WIDTH; i++) begin : g_lane
        assert property (@(posedge clk) disable iff (rst) mispredict |=> !outGroup[i].valid)
            else $error("lane %0d valid in the cycle after mispredict", i);  // flushed group

        for (genvar j = i + 1; j < `RENAME_WIDTH; j++) begin : g_other
            assert property (@(posedge clk) disable iff (rst)
                !(allocate[i] && allocate[j] && offerTags[i] == offerTags[j]))
                else $error("lanes %0d and %0d allocated tag %0d together", i, j, offerTags[i]);
        end
    end

endmodule

bind renameUnit renameUnit_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .mispredict (mispredict),
    .stall      (stall),
    .allocate   (allocate),
    .offerTags  (offerTags),
    .used       (u_tagBuffer.used),
    .outGroup   (outGroup)
);
